/* hdl/fetch_ctrl.sv */
`default_nettype none

module fetch_ctrl (
    input  logic         clk,
    input  logic         resetn,
    input  logic         id_allowin,
    input  logic         br_taken,
    input  logic         br_stall,
    input  logic         wb_ex,
    input  logic         ertn_flush,
    input  logic         inst_sram_addr_ok,
    input  logic         inst_sram_data_ok,
    output logic         inst_sram_req,
    output logic         if_id_valid,
    output logic         if_id_adef,
    pc_ctl_if.ctrl       pc,
    inst_hold_if.ctrl    hold
);
    import fetch_pkg::*;

    fetch_state_e state;
    redirect_e    live_kind;
    redirect_e    held_kind;
    logic         discard;
    logic         adef_pend;
    logic         redir;
    logic         live_win;
    logic         port_free;
    logic         go;
    logic         adef_take;
    logic         accepted;
    logic         data_use;

    // Resolve the three redirect sources, exception first.
    always_comb begin
        if (wb_ex) begin
            live_kind = redir_exc;
        end else if (ertn_flush) begin
            live_kind = redir_ertn;
        end else if (br_taken) begin
            live_kind = redir_branch;
        end else begin
            live_kind = redir_none;
        end
    end

    assign redir = (live_kind != redir_none);

    // A live redirect only replaces a held one of lower priority.
    assign live_win = (live_kind > held_kind);

    // The port is free in idle with an empty buffer, or when a redirect
    // releases the halted state.
    assign port_free = ((state == st_idle) && !hold.full) ||
                       ((state == st_halted) && redir);
    assign go        = port_free && !br_stall;
    assign adef_take = go && pc.misaligned;
    assign accepted  = inst_sram_req && inst_sram_addr_ok;
    assign data_use  = inst_sram_data_ok && !discard;

    assign inst_sram_req = go && !pc.misaligned;

    assign pc.sel        = live_win ? live_kind : redir_none;
    assign pc.pc_load    = accepted || adef_take;
    assign pc.hold_load  = live_win && !pc.pc_load;
    assign pc.hold_kind  = live_kind;
    assign pc.hold_clear = pc.pc_load;

    // Any redirect cancels what is in flight this cycle.
    assign if_id_valid = !redir && (hold.full || data_use || adef_pend);
    assign if_id_adef  = adef_pend;

    assign hold.capture     = data_use && !id_allowin && !redir;
    assign hold.release_buf = hold.full && id_allowin;
    assign hold.flush       = redir;
    assign hold.adef        = adef_pend;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_idle;
        end else if (accepted) begin
            state <= st_wait_data;
        end else if (adef_take) begin
            state <= st_halted;
        end else if ((state == st_wait_data) && inst_sram_data_ok) begin
            state <= st_idle;
        end else if ((state == st_halted) && redir) begin
            state <= st_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            held_kind <= redir_none;
        end else if (pc.pc_load) begin
            held_kind <= redir_none;
        end else if (live_win) begin
            held_kind <= live_kind;
        end
    end

    // The response still owed for a cancelled fetch is dropped when it comes.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            discard <= 1'b0;
        end else if (inst_sram_data_ok) begin
            discard <= 1'b0;
        end else if (redir && (state == st_wait_data)) begin
            discard <= 1'b1;
        end
    end

    // The address-error item is offered once and then the stage stays halted.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            adef_pend <= 1'b0;
        end else if (adef_take) begin
            adef_pend <= 1'b1;
        end else if (redir || id_allowin) begin
            adef_pend <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_if.sv */
`default_nettype none

// Control from fetch_ctrl to the PC datapath and its status back.
interface pc_ctl_if;
    import fetch_pkg::*;

    logic            pc_load;
    redirect_e       sel;
    logic            hold_load;
    redirect_e       hold_kind;
    logic            hold_clear;
    logic [xlen-1:0] next_pc;
    logic            misaligned;

    modport ctrl (output pc_load, sel, hold_load, hold_kind, hold_clear,
                  input  next_pc, misaligned);
    modport dp   (input  pc_load, sel, hold_load, hold_kind, hold_clear,
                  output next_pc, misaligned);
endinterface

// Control of the one-entry instruction buffer.
interface inst_hold_if;
    import fetch_pkg::*;

    logic            capture;
    logic            release_buf;
    logic            flush;
    logic            adef;
    logic            full;
    logic [xlen-1:0] inst;

    modport ctrl (output capture, release_buf, flush, adef, input full, inst);
    modport dp   (input  capture, release_buf, flush, adef, output full, inst);
endinterface

`default_nettype wire

/* hdl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // Address and instruction width.
    localparam int xlen = 32;

    // PC register value after reset, so that the first fetch lands on 32'h1c00_0000.
    localparam logic [xlen-1:0] reset_pc = 32'h1bff_fffc;

    // Kind of a live or held redirect.
    // The order is also the priority order, so kinds compare directly.
    typedef enum logic [1:0] {
        redir_none   = 2'd0,
        redir_branch = 2'd1,
        redir_ertn   = 2'd2,
        redir_exc    = 2'd3
    } redirect_e;

    // Fetch control states.
    // st_idle may issue, st_wait_data owes one data phase and
    // st_halted follows an address error until the next redirect.
    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_wait_data = 2'd1,
        st_halted    = 2'd2
    } fetch_state_e;

endpackage

`default_nettype wire

/* hdl/fetch_top.sv */
`default_nettype none

module fetch_top #(
    parameter logic [fetch_pkg::xlen-1:0] reset_addr = fetch_pkg::reset_pc
) (
    input  logic                        clk,
    input  logic                        resetn,

    // Decode side.
    input  logic                        id_allowin,
    output logic                        if_id_valid,
    output logic [fetch_pkg::xlen-1:0]  if_id_pc,
    output logic [fetch_pkg::xlen-1:0]  if_id_inst,
    output logic                        if_id_adef,
    input  logic                        br_taken,
    input  logic [fetch_pkg::xlen-1:0]  br_target,
    input  logic                        br_stall,

    // Exception entry and return from writeback.
    input  logic                        wb_ex,
    input  logic [fetch_pkg::xlen-1:0]  ex_entry,
    input  logic                        ertn_flush,
    input  logic [fetch_pkg::xlen-1:0]  ertn_entry,

    // Instruction SRAM, read only.
    output logic                        inst_sram_req,
    output logic [fetch_pkg::xlen-1:0]  inst_sram_addr,
    input  logic                        inst_sram_addr_ok,
    input  logic                        inst_sram_data_ok,
    input  logic [fetch_pkg::xlen-1:0]  inst_sram_rdata
);

    pc_ctl_if    pc_ctl_i ();
    inst_hold_if inst_hold_bus_i ();

    fetch_ctrl fetch_ctrl_i (
        .clk               (clk),
        .resetn            (resetn),
        .id_allowin        (id_allowin),
        .br_taken          (br_taken),
        .br_stall          (br_stall),
        .wb_ex             (wb_ex),
        .ertn_flush        (ertn_flush),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_req     (inst_sram_req),
        .if_id_valid       (if_id_valid),
        .if_id_adef        (if_id_adef),
        .pc                (pc_ctl_i.ctrl),
        .hold              (inst_hold_bus_i.ctrl)
    );

    pc_gen #(
        .reset_addr (reset_addr)
    ) pc_gen_i (
        .clk        (clk),
        .resetn     (resetn),
        .br_target  (br_target),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry),
        .pc         (if_id_pc),
        .ctl        (pc_ctl_i.dp)
    );

    inst_hold inst_hold_i (
        .clk             (clk),
        .resetn          (resetn),
        .inst_sram_rdata (inst_sram_rdata),
        .hold            (inst_hold_bus_i.dp)
    );

    // The address goes out as soon as the next PC is formed.
    assign inst_sram_addr = pc_ctl_i.next_pc;
    assign if_id_inst     = inst_hold_bus_i.inst;

endmodule

`default_nettype wire

/* hdl/inst_hold.sv */
`default_nettype none

module inst_hold (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic [fetch_pkg::xlen-1:0]  inst_sram_rdata,
    inst_hold_if.dp                     hold
);
    import fetch_pkg::*;

    logic [xlen-1:0] word;
    logic            full;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            full <= 1'b0;
        end else if (hold.flush || hold.release_buf) begin
            full <= 1'b0;
        end else if (hold.capture) begin
            full <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hold.capture) begin
            word <= inst_sram_rdata;
        end
    end

    assign hold.full = full;

    // An address-error item carries no instruction.
    always_comb begin
        if (hold.adef) begin
            hold.inst = '0;
        end else if (full) begin
            hold.inst = word;
        end else begin
            hold.inst = inst_sram_rdata;
        end
    end

endmodule

`default_nettype wire

/* hdl/pc_gen.sv */
`default_nettype none

module pc_gen #(
    parameter logic [fetch_pkg::xlen-1:0] reset_addr = fetch_pkg::reset_pc
) (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic [fetch_pkg::xlen-1:0]  br_target,
    input  logic [fetch_pkg::xlen-1:0]  ex_entry,
    input  logic [fetch_pkg::xlen-1:0]  ertn_entry,
    output logic [fetch_pkg::xlen-1:0]  pc,
    pc_ctl_if.dp                        ctl
);
    import fetch_pkg::*;

    logic [xlen-1:0] hold_target;
    logic            hold_valid;
    logic [xlen-1:0] live_target;

    always_comb begin
        case (ctl.hold_kind)
            redir_exc:  live_target = ex_entry;
            redir_ertn: live_target = ertn_entry;
            default:    live_target = br_target;
        endcase
    end

    // A live redirect selected by the controller overrides the held target.
    always_comb begin
        case (ctl.sel)
            redir_exc:    ctl.next_pc = ex_entry;
            redir_ertn:   ctl.next_pc = ertn_entry;
            redir_branch: ctl.next_pc = br_target;
            default:      ctl.next_pc = hold_valid ? hold_target : pc + 32'd4;
        endcase
    end

    assign ctl.misaligned = |ctl.next_pc[1:0];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= reset_addr;
        end else if (ctl.pc_load) begin
            pc <= ctl.next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            hold_valid <= 1'b0;
        end else if (ctl.hold_clear) begin
            hold_valid <= 1'b0;
        end else if (ctl.hold_load) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.hold_load) begin
            hold_target <= live_target;
        end
    end

endmodule

`default_nettype wire

/* project.f */
hdl/fetch_pkg.sv
hdl/fetch_if.sv
hdl/fetch_ctrl.sv
hdl/pc_gen.sv
hdl/inst_hold.sv
hdl/fetch_top.sv
test/imem_model.sv
test/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the fetch stage testbench with Verilator and runs it.
# The exit status is nonzero when the build, the run or the checks fail.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f project.f --top-module fetch_tb -o fetch_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$log"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$log"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

/* test/fetch_tb.sv */
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam int              clk_period = 100;
    localparam int              n_steps    = 14;
    localparam logic [31:0]     rng_seed   = 32'h52d6_e10a;
    localparam logic [xlen-1:0] inst_key   = 32'hc0de_0000;

    // srcs is {exception, ertn, branch}.
    // stall sets how often decode and the branch stall hold the stage.
    typedef struct packed {
        logic [7:0]      wait_cycles;
        logic [2:0]      srcs;
        logic [xlen-1:0] br_tgt;
        logic [xlen-1:0] ertn_tgt;
        logic [xlen-1:0] ex_tgt;
        logic [3:0]      stall;
    } step_t;

    step_t steps [n_steps];

    logic            clk         = 1'b0;
    logic            resetn      = 1'b0;
    logic            id_allowin  = 1'b1;
    logic            br_taken    = 1'b0;
    logic [xlen-1:0] br_target   = '0;
    logic            br_stall    = 1'b0;
    logic            wb_ex       = 1'b0;
    logic [xlen-1:0] ex_entry    = '0;
    logic            ertn_flush  = 1'b0;
    logic [xlen-1:0] ertn_entry  = '0;
    logic [3:0]      stall_level = 4'd0;
    logic [31:0]     bp_state    = 32'h9e37_79b9 ^ rng_seed;
    logic            if_id_valid;
    logic [xlen-1:0] if_id_pc;
    logic [xlen-1:0] if_id_inst;
    logic            if_id_adef;
    logic            inst_sram_req;
    logic [xlen-1:0] inst_sram_addr;
    logic            inst_sram_addr_ok;
    logic            inst_sram_data_ok;
    logic [xlen-1:0] inst_sram_rdata;

    logic [xlen-1:0] exp_pc      = '0;
    logic [xlen-1:0] held_pc     = '0;
    logic [xlen-1:0] held_inst   = '0;
    logic            held_adef   = 1'b0;
    logic            held_prev   = 1'b0;
    logic            halted      = 1'b0;
    logic            first_cycle = 1'b1;
    logic            redir_now   = 1'b0;
    int              errors      = 0;
    int              xfers       = 0;
    int              failed      = 0;

    fetch_top #(
        .reset_addr (reset_pc)
    ) fetch_top_i (
        .clk               (clk),
        .resetn            (resetn),
        .id_allowin        (id_allowin),
        .if_id_valid       (if_id_valid),
        .if_id_pc          (if_id_pc),
        .if_id_inst        (if_id_inst),
        .if_id_adef        (if_id_adef),
        .br_taken          (br_taken),
        .br_target         (br_target),
        .br_stall          (br_stall),
        .wb_ex             (wb_ex),
        .ex_entry          (ex_entry),
        .ertn_flush        (ertn_flush),
        .ertn_entry        (ertn_entry),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata)
    );

    imem_model #(
        .seed (rng_seed),
        .key  (inst_key)
    ) imem_i (
        .clk     (clk),
        .resetn  (resetn),
        .req     (inst_sram_req),
        .addr    (inst_sram_addr),
        .addr_ok (inst_sram_addr_ok),
        .data_ok (inst_sram_data_ok),
        .rdata   (inst_sram_rdata)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic flag_mismatch(input string msg);
        $display("error at time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic apply_redirect(input step_t s);
        br_target  <= s.br_tgt;
        ertn_entry <= s.ertn_tgt;
        ex_entry   <= s.ex_tgt;
        br_taken   <= s.srcs[0];
        ertn_flush <= s.srcs[1];
        wb_ex      <= s.srcs[2];
        @(posedge clk);
        br_taken   <= 1'b0;
        ertn_flush <= 1'b0;
        wb_ex      <= 1'b0;
    endtask

    // Random decode back-pressure and branch stall.
    always @(posedge clk) begin
        bp_state   <= xorshift32(bp_state);
        id_allowin <= (bp_state[3:0] >= stall_level);
        br_stall   <= (bp_state[7:4] < {1'b0, stall_level[3:1]});
    end

    // Scoreboard, sampled mid-cycle where inputs and outputs are settled.
    always @(negedge clk) begin
        redir_now = wb_ex || ertn_flush || br_taken;
        if (!resetn) begin
            exp_pc      = reset_pc + 32'd4;
            first_cycle = 1'b1;
            held_prev   = 1'b0;
            halted      = 1'b0;
        end else begin
            if (first_cycle) begin
                assert (inst_sram_req && !if_id_valid) else
                    flag_mismatch("request low or valid high after reset");
                first_cycle = 1'b0;
            end
            if (held_prev && !redir_now) begin
                assert (if_id_valid && if_id_pc == held_pc && if_id_inst == held_inst &&
                        if_id_adef == held_adef) else
                    flag_mismatch($sformatf("held item pc %h changed or dropped", held_pc));
            end
            if (halted && !redir_now) begin
                assert (!inst_sram_req) else
                    flag_mismatch("SRAM request while halted after an address error");
            end
            // A branch stall from decode blocks any new request.
            if (br_stall) begin
                assert (!inst_sram_req) else
                    flag_mismatch("SRAM request while the branch stall is high");
            end
            if (redir_now) begin
                assert (!if_id_valid) else
                    flag_mismatch("valid high in a redirect cycle");
                if (wb_ex) begin
                    exp_pc = ex_entry;
                end else if (ertn_flush) begin
                    exp_pc = ertn_entry;
                end else begin
                    exp_pc = br_target;
                end
                halted = 1'b0;
            end else if (if_id_valid && id_allowin) begin
                xfers++;
                assert (!halted) else
                    flag_mismatch($sformatf("item pc %h delivered while halted", if_id_pc));
                if (exp_pc[1:0] != 2'b00) begin
                    assert (if_id_pc == exp_pc && if_id_adef && if_id_inst == 32'h0) else
                        flag_mismatch($sformatf("address error item pc %h adef %b inst %h",
                                                if_id_pc, if_id_adef, if_id_inst));
                    halted = 1'b1;
                end else begin
                    assert (if_id_pc == exp_pc && !if_id_adef &&
                            if_id_inst == (exp_pc ^ inst_key)) else
                        flag_mismatch($sformatf("pc %h inst %h, expected pc %h inst %h",
                                                if_id_pc, if_id_inst, exp_pc,
                                                exp_pc ^ inst_key));
                    exp_pc = exp_pc + 32'd4;
                end
            end
            held_prev = if_id_valid && !id_allowin && !redir_now;
            held_pc   = if_id_pc;
            held_inst = if_id_inst;
            held_adef = if_id_adef;
        end
    end

    initial begin
        #(n_steps * 40 * clk_period);
        $display("Timeout: the tests did not finish within %0d cycles.", n_steps * 40);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int err_before;
        int start;

        steps[0]  = '{8'd60, 3'b000, 32'h0, 32'h0, 32'h0, 4'd0};
        steps[1]  = '{8'd50, 3'b000, 32'h0, 32'h0, 32'h0, 4'd6};
        steps[2]  = '{8'd10, 3'b001, 32'h1c00_1000, 32'h0, 32'h0, 4'd3};
        steps[3]  = '{8'd12, 3'b010, 32'h0, 32'h1c00_2000, 32'h0, 4'd4};
        steps[4]  = '{8'd15, 3'b100, 32'h0, 32'h0, 32'h1c00_3000, 4'd8};
        steps[5]  = '{8'd2, 3'b001, 32'h1c00_4000, 32'h0, 32'h0, 4'd2};
        steps[6]  = '{8'd3, 3'b111, 32'h1c00_5000, 32'h1c00_7000, 32'h1c00_6000, 4'd5};
        steps[7]  = '{8'd8, 3'b011, 32'h1c00_9000, 32'h1c00_8000, 32'h0, 4'd4};
        steps[8]  = '{8'd6, 3'b001, 32'h1c00_a002, 32'h0, 32'h0, 4'd3};
        steps[9]  = '{8'd20, 3'b000, 32'h0, 32'h0, 32'h0, 4'd0};
        steps[10] = '{8'd5, 3'b100, 32'h0, 32'h0, 32'h1c00_b000, 4'd6};
        steps[11] = '{8'd1, 3'b011, 32'h1c00_c100, 32'h1c00_c001, 32'h0, 4'd2};
        steps[12] = '{8'd10, 3'b001, 32'h1c00_d000, 32'h0, 32'h0, 4'd4};
        steps[13] = '{8'd40, 3'b000, 32'h0, 32'h0, 32'h0, 4'd7};

        repeat (3) @(posedge clk);
        resetn <= 1'b1;

        for (int i = 0; i < n_steps; i++) begin
            err_before = errors;
            stall_level <= steps[i].stall;
            repeat (steps[i].wait_cycles) @(posedge clk);
            if (steps[i].srcs != 3'b000) begin
                start = xfers;
                apply_redirect(steps[i]);
                // Each redirect is followed by its first item before the next test.
                while (xfers == start) begin
                    @(posedge clk);
                end
            end
            if (errors != err_before) begin
                failed++;
            end
            $display("test %0d redirect %b: %0d transfers so far, %0d errors", i,
                     steps[i].srcs, xfers, errors - err_before);
        end

        repeat (5) @(posedge clk);
        $display("%0d tests, %0d failed, %0d transfers, %0d errors", n_steps, failed, xfers,
                 errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/imem_model.sv */
`default_nettype none

// Instruction SRAM model with one outstanding read.
// Address acceptance is random per cycle and data returns 1 to 4 cycles later.
module imem_model #(
    parameter logic [31:0] seed = 32'h0000_0001,
    parameter logic [31:0] key  = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);

    logic [31:0] roll   = seed;
    logic        busy   = 1'b0;
    logic [2:0]  cnt    = 3'd0;
    logic [31:0] addr_q = 32'h0000_0000;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // About three cycles in four accept an address while the port is free.
    assign addr_ok = !busy && (roll[1:0] != 2'b00);
    assign data_ok = busy && (cnt == 3'd1);

    // Outside a data phase the read data is junk.
    assign rdata = data_ok ? (addr_q ^ key) : roll;

    always @(posedge clk) begin
        roll <= xorshift32(roll);
        if (!resetn) begin
            busy <= 1'b0;
            cnt  <= 3'd0;
        end else if (busy) begin
            if (cnt == 3'd1) begin
                busy <= 1'b0;
            end
            cnt <= cnt - 3'd1;
        end else if (req && addr_ok) begin
            busy   <= 1'b1;
            addr_q <= addr;
            cnt    <= {1'b0, roll[3:2]} + 3'd1;
        end
    end

endmodule

`default_nettype wire
